//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_icache
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /All checks passed/ { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/axi_rd_pkg.sv
`default_nettype none

package axi_rd_pkg;

  // field widths of the read channels
  localparam int unsigned ID_W = 4;
  localparam int unsigned LEN_W = 8;
  localparam int unsigned SIZE_W = 3;
  localparam int unsigned BURST_W = 2;
  localparam int unsigned RESP_W = 2;
  localparam int unsigned DATA_W = 32;

  // burst type, incrementing address
  localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;

  // beat size, 4 bytes per beat
  localparam logic [SIZE_W-1:0] SIZE_4B = 3'b010;

  // read response
  localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

//--- rtl/icache_cfg_pkg.sv
`default_nettype none

package icache_cfg_pkg;

  // ========================================
  // default cache geometry
  // ========================================
  // capacity only seeds the top-level parameter
  localparam int unsigned ICACHE_SIZE_BYTES = 1024;
  localparam int unsigned LINE_BYTES = 16;
  localparam int unsigned WAY_NUM = 4;

  // physical address and instruction word
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned INSTR_W = 32;

  // ========================================
  // derived widths for the default geometry
  // ========================================
  // byte offset inside a line
  localparam int unsigned OFS_W = $clog2(LINE_BYTES);
  // set index, one set holds WAY_NUM lines
  localparam int unsigned IDX_W = $clog2(ICACHE_SIZE_BYTES / (LINE_BYTES * WAY_NUM));
  localparam int unsigned TAG_W = ADDR_W - IDX_W - OFS_W;
  localparam int unsigned WAY_W = $clog2(WAY_NUM);
  localparam int unsigned WORDS_PER_LINE = LINE_BYTES / 4;

  // one whole line, word 0 at the lowest address
  typedef logic [WORDS_PER_LINE-1:0][INSTR_W-1:0] line_t;
  typedef logic [TAG_W-1:0] tag_t;
  // tree bits, node 0 is the root
  typedef logic [WAY_NUM-2:0] plru_t;

endpackage

`default_nettype wire

//--- rtl/icache_core.sv
`timescale 1ns/1ps
`default_nettype none

module icache_core #(
  parameter int unsigned OFS_W = icache_cfg_pkg::OFS_W,
  parameter int unsigned IDX_W = icache_cfg_pkg::IDX_W,
  parameter int unsigned TAG_W = icache_cfg_pkg::TAG_W,
  parameter int unsigned WAY_NUM = icache_cfg_pkg::WAY_NUM,
  parameter int unsigned WAY_W = icache_cfg_pkg::WAY_W,
  parameter int unsigned WORDS_PER_LINE = icache_cfg_pkg::WORDS_PER_LINE
) (
  input  wire logic clk,
  input  wire logic rst_n,
  // fetch port
  input  wire logic req_valid_i,
  output logic      req_ready_o,
  input  wire logic [icache_cfg_pkg::ADDR_W-1:0] req_addr_i,
  output logic      rsp_valid_o,
  input  wire logic rsp_ready_i,
  output logic [icache_cfg_pkg::INSTR_W-1:0] rsp_instr_o,
  output logic [icache_cfg_pkg::ADDR_W-1:0]  rsp_addr_o,
  output logic      rsp_err_o,
  // maintenance
  input  wire logic inv_valid_i,
  output logic      inv_ready_o,
  input  wire logic [IDX_W-1:0] inv_index_i,
  input  wire logic flush_i,
  // refill engine
  output logic      miss_valid_o,
  input  wire logic miss_ready_i,
  output logic [icache_cfg_pkg::ADDR_W-1:0] miss_line_addr_o,
  input  wire logic fill_valid_i,
  input  wire logic [WORDS_PER_LINE-1:0][icache_cfg_pkg::INSTR_W-1:0] fill_line_i
);

  import icache_cfg_pkg::*;

  localparam int unsigned SETS = 2 ** IDX_W;

  typedef logic [WORDS_PER_LINE-1:0][INSTR_W-1:0] way_line_t;
  typedef logic [TAG_W-1:0] way_tag_t;
  typedef logic [WAY_NUM-2:0] set_plru_t;

  // pipeline state
  logic rdy_q;
  logic s0_valid, s1_valid, s1_err, miss_sent_q;
  logic [ADDR_W-1:0] s0_addr, s1_addr;
  logic [IDX_W-1:0] s0_idx, s1_idx, rd_idx;
  way_tag_t s1_tag;
  logic rsp_hs, s1_adv, req_hs, inv_hs, fill_we, hit;

  // array ports
  way_line_t data_rd [WAY_NUM];
  way_tag_t tag_rd [WAY_NUM];
  logic [WAY_NUM-1:0] valid_rd, data_we, valid_we, hit_vec;
  logic [IDX_W-1:0] valid_waddr;
  logic valid_wdata;
  set_plru_t plru_rd, plru_new;
  logic plru_we;
  logic [WAY_W-1:0] hit_way, victim_way, access_way;
  way_line_t hit_line, sel_line;

  assign s0_idx = s0_addr[OFS_W +: IDX_W];
  assign s1_idx = s1_addr[OFS_W +: IDX_W];
  assign s1_tag = s1_addr[OFS_W + IDX_W +: TAG_W];

  // ========================================
  // handshakes and stage control
  // ========================================
  assign rsp_hs = rsp_valid_o & rsp_ready_i;
  // stage 1 takes the stage-0 entry when empty or when its response leaves
  assign s1_adv = (~s1_valid | rsp_hs) & ~flush_i;
  assign req_ready_o = rdy_q & s1_adv & ~inv_valid_i;
  assign req_hs = req_valid_i & req_ready_o;
  // fill and invalidate share the valid array write port
  assign inv_ready_o = rdy_q & s1_adv & ~fill_we;
  assign inv_hs = inv_valid_i & inv_ready_o;
  assign rd_idx = s1_adv ? s0_idx : s1_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_q <= 1'b0;
      s0_valid <= 1'b0;
      s1_valid <= 1'b0;
      s1_err <= 1'b0;
      miss_sent_q <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
      if (req_hs) begin
        s0_valid <= 1'b1;
      end else if (s1_adv) begin
        s0_valid <= 1'b0;
      end
      if (flush_i) begin
        s1_valid <= 1'b0;
        miss_sent_q <= 1'b0;
      end else if (s1_adv) begin
        s1_valid <= s0_valid;
        s1_err <= (s0_addr[1:0] != 2'b00);
        miss_sent_q <= 1'b0;
      end else if (miss_valid_o && miss_ready_i) begin
        miss_sent_q <= 1'b1;
      end else if (fill_we) begin
        miss_sent_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_hs) begin
      s0_addr <= req_addr_i;
    end
    if (s1_adv) begin
      s1_addr <= s0_addr;
    end
  end

  // ========================================
  // tag compare and response
  // ========================================
  always_comb begin
    hit_way = '0;
    hit_line = '0;
    for (int i = 0; i < WAY_NUM; i++) begin
      hit_vec[i] = valid_rd[i] & (tag_rd[i] == s1_tag);
      if (hit_vec[i]) begin
        hit_way = WAY_W'(i);
      end
      hit_line = hit_line | (data_rd[i] & {$bits(way_line_t){hit_vec[i]}});
    end
  end

  assign hit = s1_valid & ~s1_err & (|hit_vec);
  // fill only counts for the entry that issued the miss
  assign fill_we = fill_valid_i & miss_sent_q & s1_valid;
  assign sel_line = fill_we ? fill_line_i : hit_line;

  assign rsp_valid_o = s1_valid & (s1_err | hit | fill_we);
  assign rsp_instr_o = s1_err ? '0 : sel_line[s1_addr[OFS_W-1:2]];
  assign rsp_addr_o = s1_addr;
  assign rsp_err_o = s1_err;

  assign miss_valid_o = s1_valid & ~s1_err & ~hit & ~miss_sent_q;
  assign miss_line_addr_o = {s1_addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};

  // ========================================
  // replacement and arrays
  // ========================================
  assign access_way = fill_we ? victim_way : hit_way;
  assign plru_we = rsp_hs & ~s1_err;

  plru_tree #(
    .WAY_NUM(WAY_NUM)
  ) plru_tree_inst (
    .plru_bits_i (plru_rd),
    .access_way_i(access_way),
    .victim_way_o(victim_way),
    .plru_bits_o (plru_new)
  );

  assign valid_waddr = inv_hs ? inv_index_i : s1_idx;
  assign valid_wdata = ~inv_hs;

  for (genvar g = 0; g < WAY_NUM; g++) begin : g_way
    assign data_we[g] = fill_we & (victim_way == WAY_W'(g));
    // invalidate clears every way of the set
    assign valid_we[g] = inv_hs | data_we[g];

    sdp_ram #(
      .DEPTH(SETS),
      .payload_t(way_line_t)
    ) data_ram_inst (
      .clk, .rst_n,
      .we_i(data_we[g]), .waddr_i(s1_idx), .wdata_i(fill_line_i),
      .raddr_i(rd_idx), .rdata_o(data_rd[g])
    );

    sdp_ram #(
      .DEPTH(SETS),
      .payload_t(way_tag_t)
    ) tag_ram_inst (
      .clk, .rst_n,
      .we_i(data_we[g]), .waddr_i(s1_idx), .wdata_i(s1_tag),
      .raddr_i(rd_idx), .rdata_o(tag_rd[g])
    );

    sdp_ram #(
      .DEPTH(SETS),
      .payload_t(logic),
      .CLEAR_ON_RESET(1'b1)
    ) valid_ram_inst (
      .clk, .rst_n,
      .we_i(valid_we[g]), .waddr_i(valid_waddr), .wdata_i(valid_wdata),
      .raddr_i(rd_idx), .rdata_o(valid_rd[g])
    );
  end

  sdp_ram #(
    .DEPTH(SETS),
    .payload_t(set_plru_t)
  ) plru_ram_inst (
    .clk, .rst_n,
    .we_i(plru_we), .waddr_i(s1_idx), .wdata_i(plru_new),
    .raddr_i(rd_idx), .rdata_o(plru_rd)
  );

endmodule

`default_nettype wire

//--- rtl/icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill #(
  parameter int unsigned OFS_W = icache_cfg_pkg::OFS_W,
  parameter int unsigned WORDS_PER_LINE = icache_cfg_pkg::WORDS_PER_LINE
) (
  input  wire logic clk,
  input  wire logic rst_n,
  // miss request from the core
  input  wire logic miss_valid_i,
  output logic      miss_ready_o,
  input  wire logic [icache_cfg_pkg::ADDR_W-1:0] miss_line_addr_i,
  // assembled line back to the core
  output logic      fill_valid_o,
  output logic [WORDS_PER_LINE-1:0][icache_cfg_pkg::INSTR_W-1:0] fill_line_o,
  // read address channel
  output logic      ar_valid_o,
  input  wire logic ar_ready_i,
  output logic [icache_cfg_pkg::ADDR_W-1:0] ar_addr_o,
  output logic [axi_rd_pkg::LEN_W-1:0]      ar_len_o,
  output logic [axi_rd_pkg::SIZE_W-1:0]     ar_size_o,
  output logic [axi_rd_pkg::BURST_W-1:0]    ar_burst_o,
  output logic [axi_rd_pkg::ID_W-1:0]       ar_id_o,
  // read data channel
  input  wire logic r_valid_i,
  output logic      r_ready_o,
  input  wire logic [axi_rd_pkg::DATA_W-1:0] r_data_i,
  input  wire logic r_last_i,
  input  wire logic [axi_rd_pkg::RESP_W-1:0] r_resp_i
);

  import icache_cfg_pkg::*;
  import axi_rd_pkg::*;

  localparam int unsigned CNT_W = $clog2(WORDS_PER_LINE);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_e;

  state_e state_q;
  logic [ADDR_W-1:0] addr_q;
  logic [CNT_W-1:0] cnt_q;
  logic err_q;
  logic beat_bad;
  logic [WORDS_PER_LINE-1:0][INSTR_W-1:0] buf_q;

  assign miss_ready_o = (state_q == ST_IDLE);
  assign beat_bad = (r_resp_i != RESP_OKAY);

  // ========================================
  // burst request, one line per miss
  // ========================================
  assign ar_valid_o = (state_q == ST_ADDR);
  assign ar_addr_o = {addr_q[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
  assign ar_len_o = LEN_W'(WORDS_PER_LINE - 1);
  assign ar_size_o = SIZE_4B;
  assign ar_burst_o = BURST_INCR;
  assign ar_id_o = '0;
  assign r_ready_o = (state_q == ST_DATA);
  assign fill_line_o = buf_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      cnt_q <= '0;
      err_q <= 1'b0;
      fill_valid_o <= 1'b0;
    end else begin
      fill_valid_o <= 1'b0;
      case (state_q)
        ST_IDLE: if (miss_valid_i) state_q <= ST_ADDR;
        ST_ADDR: begin
          if (ar_ready_i) begin
            state_q <= ST_DATA;
            cnt_q <= '0;
            err_q <= 1'b0;
          end
        end
        ST_DATA: begin
          if (r_valid_i) begin
            cnt_q <= cnt_q + 1'b1;
            err_q <= err_q | beat_bad;
            if (r_last_i) begin
              // any failed beat sends the whole burst again
              if (err_q || beat_bad) begin
                state_q <= ST_ADDR;
              end else begin
                state_q <= ST_IDLE;
                fill_valid_o <= 1'b1;
              end
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // line address and beat buffer
  always_ff @(posedge clk) begin
    if (miss_valid_i && miss_ready_o) begin
      addr_q <= miss_line_addr_i;
    end
    if ((state_q == ST_DATA) && r_valid_i) begin
      buf_q[cnt_q] <= r_data_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int unsigned LINE_BYTES = icache_cfg_pkg::LINE_BYTES,
  parameter int unsigned WAY_NUM = icache_cfg_pkg::WAY_NUM,
  parameter int unsigned ICACHE_SIZE_BYTES = icache_cfg_pkg::ICACHE_SIZE_BYTES,
  // geometry seen by the children
  localparam int unsigned OFS_W = $clog2(LINE_BYTES),
  localparam int unsigned IDX_W = $clog2(ICACHE_SIZE_BYTES / (LINE_BYTES * WAY_NUM)),
  localparam int unsigned TAG_W = icache_cfg_pkg::ADDR_W - IDX_W - OFS_W,
  localparam int unsigned WAY_W = $clog2(WAY_NUM),
  localparam int unsigned WORDS_PER_LINE = LINE_BYTES / 4
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic req_valid_i,
  output logic      req_ready_o,
  input  wire logic [icache_cfg_pkg::ADDR_W-1:0] req_addr_i,
  output logic      rsp_valid_o,
  input  wire logic rsp_ready_i,
  output logic [icache_cfg_pkg::INSTR_W-1:0] rsp_instr_o,
  output logic [icache_cfg_pkg::ADDR_W-1:0]  rsp_addr_o,
  output logic      rsp_err_o,
  input  wire logic inv_valid_i,
  output logic      inv_ready_o,
  input  wire logic [IDX_W-1:0] inv_index_i,
  input  wire logic flush_i,
  output logic      ar_valid_o,
  input  wire logic ar_ready_i,
  output logic [icache_cfg_pkg::ADDR_W-1:0] ar_addr_o,
  output logic [axi_rd_pkg::LEN_W-1:0]      ar_len_o,
  output logic [axi_rd_pkg::SIZE_W-1:0]     ar_size_o,
  output logic [axi_rd_pkg::BURST_W-1:0]    ar_burst_o,
  output logic [axi_rd_pkg::ID_W-1:0]       ar_id_o,
  input  wire logic r_valid_i,
  output logic      r_ready_o,
  input  wire logic [axi_rd_pkg::DATA_W-1:0] r_data_i,
  input  wire logic r_last_i,
  input  wire logic [axi_rd_pkg::RESP_W-1:0] r_resp_i
);

  import icache_cfg_pkg::*;

  // core to refill engine
  logic miss_valid, miss_ready, fill_valid;
  logic [ADDR_W-1:0] miss_line_addr;
  logic [WORDS_PER_LINE-1:0][INSTR_W-1:0] fill_line;

  icache_core #(
    .OFS_W(OFS_W), .IDX_W(IDX_W), .TAG_W(TAG_W),
    .WAY_NUM(WAY_NUM), .WAY_W(WAY_W), .WORDS_PER_LINE(WORDS_PER_LINE)
  ) icache_core_inst (
    .clk, .rst_n,
    .req_valid_i, .req_ready_o, .req_addr_i,
    .rsp_valid_o, .rsp_ready_i, .rsp_instr_o, .rsp_addr_o, .rsp_err_o,
    .inv_valid_i, .inv_ready_o, .inv_index_i, .flush_i,
    .miss_valid_o(miss_valid), .miss_ready_i(miss_ready),
    .miss_line_addr_o(miss_line_addr),
    .fill_valid_i(fill_valid), .fill_line_i(fill_line)
  );

  icache_refill #(
    .OFS_W(OFS_W), .WORDS_PER_LINE(WORDS_PER_LINE)
  ) icache_refill_inst (
    .clk, .rst_n,
    .miss_valid_i(miss_valid), .miss_ready_o(miss_ready),
    .miss_line_addr_i(miss_line_addr),
    .fill_valid_o(fill_valid), .fill_line_o(fill_line),
    .ar_valid_o, .ar_ready_i, .ar_addr_o, .ar_len_o, .ar_size_o, .ar_burst_o, .ar_id_o,
    .r_valid_i, .r_ready_o, .r_data_i, .r_last_i, .r_resp_i
  );

endmodule

`default_nettype wire

//--- rtl/plru_tree.sv
`timescale 1ns/1ps
`default_nettype none

module plru_tree #(
  parameter int unsigned WAY_NUM = icache_cfg_pkg::WAY_NUM,
  localparam int unsigned WAY_W = $clog2(WAY_NUM)
) (
  input  wire logic [WAY_NUM-2:0] plru_bits_i,
  input  wire logic [WAY_W-1:0]   access_way_i,
  output logic [WAY_W-1:0]        victim_way_o,
  output logic [WAY_NUM-2:0]      plru_bits_o
);

  // tree stored as a heap: children of node n are 2n+1 and 2n+2
  // a node bit names the less recent child, 0 left and 1 right

  // ========================================
  // victim walk from the root
  // ========================================
  always_comb begin
    int unsigned node;
    node = 0;
    victim_way_o = '0;
    for (int lvl = 0; lvl < WAY_W; lvl++) begin
      victim_way_o[WAY_W-1-lvl] = plru_bits_i[node];
      if (plru_bits_i[node]) begin
        node = 2 * node + 2;
      end else begin
        node = 2 * node + 1;
      end
    end
  end

  // ========================================
  // update along the accessed path
  // ========================================
  always_comb begin
    int unsigned node;
    logic dir;
    node = 0;
    plru_bits_o = plru_bits_i;
    for (int lvl = 0; lvl < WAY_W; lvl++) begin
      dir = access_way_i[WAY_W-1-lvl];
      // point away from the way just used
      plru_bits_o[node] = ~dir;
      if (dir) begin
        node = 2 * node + 2;
      end else begin
        node = 2 * node + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/sdp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
  parameter int unsigned DEPTH = 16,
  parameter type payload_t = logic [31:0],
  parameter bit CLEAR_ON_RESET = 1'b0,
  localparam int unsigned AW = $clog2(DEPTH)
) (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     we_i,
  input  wire logic [AW-1:0] waddr_i,
  input  wire payload_t wdata_i,
  input  wire logic [AW-1:0] raddr_i,
  output payload_t      rdata_o
);

  payload_t mem [DEPTH];

  // write port
  if (CLEAR_ON_RESET) begin : g_clr_array
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        for (int i = 0; i < DEPTH; i++) begin
          mem[i] <= '0;
        end
      end else if (we_i) begin
        mem[waddr_i] <= wdata_i;
      end
    end
  end else begin : g_plain_array
    always_ff @(posedge clk) begin
      if (we_i) begin
        mem[waddr_i] <= wdata_i;
      end
    end
  end

  // registered read, write-first on an address match
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_o <= '0;
    end else if (we_i && (waddr_i == raddr_i)) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

`default_nettype wire

//--- sim.f
rtl/icache_cfg_pkg.sv
rtl/axi_rd_pkg.sv
rtl/sdp_ram.sv
rtl/plru_tree.sv
rtl/icache_refill.sv
rtl/icache_core.sv
rtl/icache_top.sv
verif/axi_mem_model.sv
verif/tb_icache.sv

//--- verif/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic ar_valid_i,
  output logic      ar_ready_o,
  input  wire logic [31:0] ar_addr_i,
  input  wire logic [axi_rd_pkg::LEN_W-1:0] ar_len_i,
  output logic      r_valid_o,
  input  wire logic r_ready_i,
  output logic [axi_rd_pkg::DATA_W-1:0] r_data_o,
  output logic      r_last_o,
  output logic [axi_rd_pkg::RESP_W-1:0] r_resp_o
);

  import axi_rd_pkg::*;

  // word value rule of the memory
  localparam logic [31:0] MEM_KEY = 32'hC0DE_0000;

  logic busy;
  logic stall;
  logic [31:0] addr;
  int unsigned left;

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o = 1'b0;
    r_data_o = '0;
    r_last_o = 1'b0;
    r_resp_o = RESP_OKAY;
    busy = 1'b0;
    stall = 1'b0;
    addr = '0;
    left = 0;
  end

  always @(posedge clk) begin
    // beat offered but not taken at this edge
    stall = r_valid_o && !r_ready_i;
    if (rst_n) begin
      // sample the handshakes of this edge
      if (ar_valid_i && ar_ready_o) begin
        busy = 1'b1;
        addr = ar_addr_i;
        left = ar_len_i + 1;
      end
      if (r_valid_o && r_ready_i) begin
        addr = addr + 4;
        left = left - 1;
        if (left == 0) begin
          busy = 1'b0;
        end
      end
    end
    #1;
    if (!rst_n) begin
      ar_ready_o = 1'b0;
      r_valid_o = 1'b0;
    end else begin
      ar_ready_o = !busy && ($urandom % 4 != 0);
      // a beat already offered stays up until taken
      if (!stall) begin
        r_valid_o = busy && ($urandom % 3 != 0);
      end
      r_data_o = addr ^ MEM_KEY;
      r_last_o = busy && (left == 1);
      r_resp_o = RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  localparam int LINE_BYTES = 16;
  localparam int WAY_NUM = 4;
  localparam int CACHE_BYTES = 1024;
  localparam int OFS_W = $clog2(LINE_BYTES);
  localparam int IDX_W = $clog2(CACHE_BYTES / (LINE_BYTES * WAY_NUM));
  localparam int TAG_W = 32 - IDX_W - OFS_W;
  localparam int WAY_W = $clog2(WAY_NUM);
  localparam int WPL = LINE_BYTES / 4;
  localparam int SETS = 2 ** IDX_W;
  localparam logic [31:0] MEM_KEY = 32'hC0DE_0000;
  // ========================================
  // run length bounds
  // ========================================
  localparam int NUM_REQ = 100;
  localparam int MISS_LAT = 4 * (WPL + 4);
  localparam longint WATCHDOG_NS = (8 + NUM_REQ * MISS_LAT * 2) * 100;

  logic clk = 1'b0;
  logic rst_n;
  logic req_valid_i, req_ready_o, rsp_valid_o, rsp_ready_i, rsp_err_o;
  logic [31:0] req_addr_i, rsp_instr_o, rsp_addr_o, ar_addr_o, r_data_i;
  logic inv_valid_i, inv_ready_o, flush_i;
  logic [IDX_W-1:0] inv_index_i;
  logic ar_valid_o, ar_ready_i, r_valid_i, r_ready_o, r_last_i;
  logic [7:0] ar_len_o;
  logic [2:0] ar_size_o;
  logic [1:0] ar_burst_o, r_resp_i;
  logic [3:0] ar_id_o;

  // reference model state
  logic m_valid [SETS][WAY_NUM];
  logic [TAG_W-1:0] m_tag [SETS][WAY_NUM];
  logic [WAY_NUM-2:0] m_plru [SETS];
  logic [31:0] pend_q [$];
  int ar_cnt, exp_ar, val_err, gen_err;
  logic bp_on;
  // burst open between address handshake and last beat
  logic in_burst;

  icache_top #(
    .LINE_BYTES(LINE_BYTES), .WAY_NUM(WAY_NUM), .ICACHE_SIZE_BYTES(CACHE_BYTES)
  ) icache_top_inst (
    .clk, .rst_n, .req_valid_i, .req_ready_o, .req_addr_i,
    .rsp_valid_o, .rsp_ready_i, .rsp_instr_o, .rsp_addr_o, .rsp_err_o,
    .inv_valid_i, .inv_ready_o, .inv_index_i, .flush_i,
    .ar_valid_o, .ar_ready_i, .ar_addr_o, .ar_len_o, .ar_size_o, .ar_burst_o, .ar_id_o,
    .r_valid_i, .r_ready_o, .r_data_i, .r_last_i, .r_resp_i
  );

  axi_mem_model mem_inst (
    .clk, .rst_n, .ar_valid_i(ar_valid_o), .ar_ready_o(ar_ready_i),
    .ar_addr_i(ar_addr_o), .ar_len_i(ar_len_o), .r_valid_o(r_valid_i),
    .r_ready_i(r_ready_o), .r_data_o(r_data_i), .r_last_o(r_last_i), .r_resp_o(r_resp_i)
  );

  always #50 clk = ~clk;

  // ========================================
  // tree PLRU reference
  // ========================================
  function automatic int pick_victim(input logic [WAY_NUM-2:0] t);
    int n;
    int w;
    n = 0;
    w = 0;
    for (int l = 0; l < WAY_W; l++) begin
      w = 2 * w + int'(t[n]);
      n = 2 * n + 1 + int'(t[n]);
    end
    return w;
  endfunction

  function automatic logic [WAY_NUM-2:0] touch(input logic [WAY_NUM-2:0] t, input int way);
    int n;
    int b;
    logic [WAY_NUM-2:0] r;
    n = 0;
    r = t;
    for (int l = 0; l < WAY_W; l++) begin
      b = (way >> (WAY_W - 1 - l)) & 1;
      r[n] = (b == 0);
      n = 2 * n + 1 + b;
    end
    return r;
  endfunction

  // returns 1 when the access needs a refill
  function automatic bit model_access(input logic [31:0] a);
    int s;
    int hw;
    int v;
    logic [TAG_W-1:0] tg;
    s = int'(a[OFS_W +: IDX_W]);
    tg = a[31 -: TAG_W];
    hw = -1;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == tg) hw = w;
    end
    if (hw >= 0) begin
      m_plru[s] = touch(m_plru[s], hw);
      return 1'b0;
    end
    v = pick_victim(m_plru[s]);
    m_valid[s][v] = 1'b1;
    m_tag[s][v] = tg;
    m_plru[s] = touch(m_plru[s], v);
    return 1'b1;
  endfunction

  // ========================================
  // checks
  // ========================================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got == want) else begin
      val_err++;
      $display("FAIL %0t %s got %0h exp %0h", $time, name, got, want);
    end
  endtask

  always @(posedge clk) begin
    logic [31:0] exp;
    if (rst_n) begin
      check_value("r_ready_o", 32'(r_ready_o), 32'(in_burst));
      if (r_valid_i && r_ready_o && r_last_i) in_burst = 1'b0;
      // burst request belongs to the oldest outstanding fetch
      if (ar_valid_o) begin
        if (pend_q.size() == 0) begin
          gen_err++;
          $display("address request at %0t with no fetch outstanding", $time);
        end else begin
          check_value("ar_addr_o", ar_addr_o, pend_q[0] & ~32'(LINE_BYTES - 1));
        end
        check_value("ar_len_o", 32'(ar_len_o), WPL - 1);
        check_value("ar_size_o", 32'(ar_size_o), 32'h2);
        check_value("ar_burst_o", 32'(ar_burst_o), 32'h1);
        check_value("ar_id_o", 32'(ar_id_o), 32'h0);
      end
      if (ar_valid_o && ar_ready_i) begin
        ar_cnt++;
        in_burst = 1'b1;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        if (pend_q.size() == 0) begin
          gen_err++;
          $display("response at %0t with no request outstanding", $time);
        end else begin
          exp = pend_q.pop_front();
          check_value("rsp_addr_o", rsp_addr_o, exp);
          check_value("rsp_err_o", 32'(rsp_err_o), 32'(exp[1:0] != 2'b00));
          if (exp[1:0] == 2'b00) begin
            check_value("rsp_instr_o", rsp_instr_o, exp ^ MEM_KEY);
            exp_ar += int'(model_access(exp));
          end
          check_value("ar handshake count", ar_cnt, exp_ar);
        end
      end
    end
  end

  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid_o && !rsp_ready_i) |=>
      (rsp_valid_o && $stable(rsp_instr_o) && $stable(rsp_addr_o)))
    else begin
      gen_err++;
      $display("stalled response changed or dropped at %0t", $time);
    end

  // response back-pressure
  always @(posedge clk) begin
    #1;
    rsp_ready_i = bp_on ? ($urandom % 3 != 0) : 1'b1;
  end

  // ========================================
  // stimulus tasks
  // ========================================
  task automatic fetch(input logic [31:0] addr);
    req_valid_i = 1'b1;
    req_addr_i = addr;
    do @(posedge clk); while (!req_ready_o);
    pend_q.push_back(addr);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (pend_q.size() != 0) @(posedge clk);
    #1;
  endtask

  task automatic invalidate(input int idx);
    inv_valid_i = 1'b1;
    inv_index_i = IDX_W'(idx);
    do @(posedge clk); while (!inv_ready_o);
    for (int w = 0; w < WAY_NUM; w++) m_valid[idx][w] = 1'b0;
    #1;
    inv_valid_i = 1'b0;
  endtask

  task automatic end_run();
    $display("value errors %0d, other errors %0d", val_err, gen_err);
    if (val_err + gen_err == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("run timed out before all requests completed");
    $display("Checks failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h5b2f));
    rst_n = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i = '0;
    rsp_ready_i = 1'b1;
    inv_valid_i = 1'b0;
    inv_index_i = '0;
    flush_i = 1'b0;
    bp_on = 1'b0;
    in_burst = 1'b0;
    ar_cnt = 0;
    exp_ar = 0;
    val_err = 0;
    gen_err = 0;
    for (int s = 0; s < SETS; s++) begin
      m_plru[s] = '0;
      for (int w = 0; w < WAY_NUM; w++) m_valid[s][w] = 1'b0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // sequential words, one miss per line
    for (int a = 32'h1000; a < 32'h1040; a += 4) fetch(a);
    fetch(32'h1000);
    drain();
    // WAY_NUM+1 lines in set 3, then revisit all
    for (int t = 0; t <= WAY_NUM; t++) fetch((t << (OFS_W + IDX_W)) | (3 << OFS_W));
    for (int t = 0; t <= WAY_NUM; t++) fetch((t << (OFS_W + IDX_W)) | (3 << OFS_W) | 8);
    drain();
    invalidate(3);
    fetch((1 << (OFS_W + IDX_W)) | (3 << OFS_W));
    // misaligned addresses
    fetch(32'h1002);
    fetch(32'h2001);
    drain();

    // flush while the refill is running
    fetch(32'h7770);
    do @(posedge clk); while (!(ar_valid_o && ar_ready_i));
    #1;
    flush_i = 1'b1;
    @(posedge clk);
    #1;
    flush_i = 1'b0;
    void'(pend_q.pop_front());
    exp_ar++;
    do @(posedge clk); while (!(r_valid_i && r_ready_o && r_last_i));
    #1;
    fetch(32'h7774);
    drain();

    // random traffic with back-pressure
    bp_on = 1'b1;
    for (int i = 0; i < 60; i++) begin
      fetch(((($urandom % 8) << 8) | (($urandom % 4) << 4) | (($urandom % 4) << 2)) |
            (($urandom % 16 == 0) ? 32'h2 : 32'h0));
    end
    drain();
    end_run();
  end

endmodule

`default_nettype wire
